// ==== isaPkg.sv ====
package isaPkg;

    localparam int DATA_WIDTH      = 16;
    localparam int IMM_WIDTH       = 8;
    localparam int SHORT_IMM_WIDTH = 5;   // imm field of the I-format group

    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_STU   = 5'b10011,
        OP_ROLI  = 5'b10100,
        OP_SLLI  = 5'b10101,
        OP_RORI  = 5'b10110,
        OP_SRLI  = 5'b10111,
        OP_LBI   = 5'b11000,
        OP_BTR   = 5'b11001,
        OP_SHIFT = 5'b11010,   // rol, sll, ror, srl
        OP_ARITH = 5'b11011,   // add, sub, xor, andn
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_t;

    typedef logic [1:0] funct_t;

    // same two bits mean different things per group
    localparam funct_t FN_ADD  = 2'b00;
    localparam funct_t FN_SUB  = 2'b01;
    localparam funct_t FN_XOR  = 2'b10;
    localparam funct_t FN_ANDN = 2'b11;
    localparam funct_t FN_ROL  = 2'b00;
    localparam funct_t FN_SLL  = 2'b01;
    localparam funct_t FN_ROR  = 2'b10;
    localparam funct_t FN_SRL  = 2'b11;

endpackage

// ==== execPkg.sv ====
package execPkg;

    typedef enum logic [2:0] {
        ALU_ROL = 3'd0,
        ALU_SLL = 3'd1,
        ALU_ROR = 3'd2,
        ALU_SRL = 3'd3,
        ALU_ADD = 3'd4,
        ALU_OR  = 3'd5,
        ALU_XOR = 3'd6,
        ALU_AND = 3'd7
    } aluOp_t;

    typedef enum logic [3:0] {
        RES_ALU, RES_SEQ, RES_SLT, RES_SLE, RES_SCO, RES_BTR,
        RES_BLTZ, RES_BGEZ, RES_NONE,
        RES_STORE              // alu value, no writeback
    } resultSel_t;

    typedef struct packed {
        logic       invA;
        logic       invB;
        logic       sign;      // signed overflow detect
        logic       cin;
        aluOp_t     op;
        resultSel_t resultSel;
    } aluCtrl_t;

    typedef struct packed {
        logic                            valid;
        isaPkg::opcode_t                 opcode;
        isaPkg::funct_t                  funct;
        logic [isaPkg::DATA_WIDTH-1:0]   rs;
        logic [isaPkg::DATA_WIDTH-1:0]   rt;
        logic [isaPkg::IMM_WIDTH-1:0]    imm;
    } execReq_t;

    typedef struct packed {
        logic                            valid;
        logic                            writeEn;
        logic [isaPkg::DATA_WIDTH-1:0]   value;
        logic                            isBranch;
        logic                            branchTaken;
    } execResult_t;

endpackage

// ==== aluControl.sv ====
module aluControl (
    input  isaPkg::opcode_t    opcode,
    input  isaPkg::funct_t     funct,
    output execPkg::aluCtrl_t  ctrl
);
    import isaPkg::*;
    import execPkg::*;

    always_comb begin
        ctrl.invA      = 1'b0;
        ctrl.invB      = 1'b0;
        ctrl.sign      = 1'b0;
        ctrl.cin       = 1'b0;
        ctrl.op        = ALU_ROL;
        ctrl.resultSel = RES_NONE;   // halt, nop and anything unknown

        case (opcode)
            OP_ADDI: begin
                ctrl.sign      = 1'b1;
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_ALU;
            end
            OP_SUBI: begin
                ctrl.invA      = 1'b1;   // imm - rs
                ctrl.cin       = 1'b1;
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_ALU;
            end
            OP_XORI: begin
                ctrl.op        = ALU_XOR;
                ctrl.resultSel = RES_ALU;
            end
            OP_ANDNI: begin
                ctrl.invB      = 1'b1;
                ctrl.op        = ALU_AND;
                ctrl.resultSel = RES_ALU;
            end
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
                ctrl.op        = aluOp_t'({1'b0, opcode[1:0]});   // low bits give the mode
                ctrl.resultSel = RES_ALU;
            end
            OP_ST: begin
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_STORE;
            end
            OP_LD, OP_STU, OP_LBI: begin
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_ALU;
            end
            OP_SLBI: begin
                ctrl.op        = ALU_OR;
                ctrl.resultSel = RES_ALU;
            end
            OP_BTR: begin
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_BTR;
            end
            OP_ARITH: begin
                ctrl.resultSel = RES_ALU;
                case (funct)
                    FN_ADD:  ctrl.op = ALU_ADD;
                    FN_SUB: begin
                        ctrl.invA = 1'b1;
                        ctrl.cin  = 1'b1;
                        ctrl.op   = ALU_ADD;
                    end
                    FN_XOR:  ctrl.op = ALU_XOR;
                    default: begin   // andn
                        ctrl.invB = 1'b1;
                        ctrl.op   = ALU_AND;
                    end
                endcase
            end
            OP_SHIFT: begin
                ctrl.resultSel = RES_ALU;
                case (funct)
                    FN_ROL:  ctrl.op = ALU_ROL;
                    FN_SLL:  ctrl.op = ALU_SLL;
                    FN_ROR:  ctrl.op = ALU_ROR;
                    default: ctrl.op = ALU_SRL;
                endcase
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_BLTZ, OP_BGEZ: begin
                ctrl.sign = 1'b1;
                ctrl.invB = 1'b1;   // rs - rt
                ctrl.cin  = 1'b1;
                ctrl.op   = ALU_ADD;
                case (opcode)
                    OP_SEQ:  ctrl.resultSel = RES_SEQ;
                    OP_SLT:  ctrl.resultSel = RES_SLT;
                    OP_SLE:  ctrl.resultSel = RES_SLE;
                    OP_BLTZ: ctrl.resultSel = RES_BLTZ;
                    default: ctrl.resultSel = RES_BGEZ;
                endcase
            end
            OP_SCO: begin
                ctrl.op        = ALU_ADD;
                ctrl.resultSel = RES_SCO;
            end
            default: ;
        endcase
    end

    // adder would otherwise compute -(a + b) - 2
    invNotBoth: assert final (!(ctrl.invA && ctrl.invB))
        else $error("aluControl: invA and invB both set for opcode %b", opcode);

endmodule

// ==== operandSelect.sv ====
module operandSelect (
    input  isaPkg::opcode_t                 opcode,
    input  logic [isaPkg::DATA_WIDTH-1:0]   rs,
    input  logic [isaPkg::DATA_WIDTH-1:0]   rt,
    input  logic [isaPkg::IMM_WIDTH-1:0]    imm,
    output logic [isaPkg::DATA_WIDTH-1:0]   opA,
    output logic [isaPkg::DATA_WIDTH-1:0]   opB
);
    import isaPkg::*;

    logic [DATA_WIDTH-1:0] shortSext, shortZext, longSext, longZext;

    assign shortSext = {{(DATA_WIDTH-SHORT_IMM_WIDTH){imm[SHORT_IMM_WIDTH-1]}},
                        imm[SHORT_IMM_WIDTH-1:0]};
    assign shortZext = {{(DATA_WIDTH-SHORT_IMM_WIDTH){1'b0}}, imm[SHORT_IMM_WIDTH-1:0]};
    assign longSext  = {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    assign longZext  = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};

    always_comb begin
        opA = rs;
        opB = rt;
        case (opcode)
            OP_XORI, OP_ANDNI: opB = shortZext;   // logic ops zero-extend
            OP_ADDI, OP_SUBI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
            OP_ST, OP_LD, OP_STU: opB = shortSext;
            OP_LBI: begin
                opA = '0;
                opB = longSext;
            end
            OP_SLBI: begin
                opA = {rs[DATA_WIDTH-IMM_WIDTH-1:0], {IMM_WIDTH{1'b0}}};
                opB = longZext;   // or'ed into the low byte
            end
            OP_BLTZ, OP_BGEZ: opB = '0;   // compare rs against zero
            default: ;
        endcase
    end

endmodule

// ==== shifter.sv ====
module shifter (
    input  logic [isaPkg::DATA_WIDTH-1:0]   data,
    input  logic [3:0]                      amount,
    input  logic [1:0]                      mode,     // rol, sll, ror, srl
    output logic [isaPkg::DATA_WIDTH-1:0]   shifted
);
    import isaPkg::*;

    logic [DATA_WIDTH-1:0] stage [0:4];

    assign stage[0] = data;

    for (genvar k = 0; k < 4; k++) begin : gStage
        localparam int SH = 1 << k;   // 1, 2, 4, 8
        logic [DATA_WIDTH-1:0] moved;

        always_comb begin
            case (mode)
                2'd0:    moved = {stage[k][DATA_WIDTH-1-SH:0], stage[k][DATA_WIDTH-1:DATA_WIDTH-SH]};
                2'd1:    moved = {stage[k][DATA_WIDTH-1-SH:0], {SH{1'b0}}};
                2'd2:    moved = {stage[k][SH-1:0], stage[k][DATA_WIDTH-1:SH]};
                default: moved = {{SH{1'b0}}, stage[k][DATA_WIDTH-1:SH]};
            endcase
        end

        assign stage[k+1] = amount[k] ? moved : stage[k];
    end

    assign shifted = stage[4];

endmodule

// ==== aluCore.sv ====
module aluCore (
    input  logic [isaPkg::DATA_WIDTH-1:0]   opA,
    input  logic [isaPkg::DATA_WIDTH-1:0]   opB,
    input  execPkg::aluCtrl_t               ctrl,
    output logic [isaPkg::DATA_WIDTH-1:0]   aluOut,
    output logic                            carryOut,
    output logic                            overflow,
    output logic                            zero,
    output logic                            negative
);
    import isaPkg::*;
    import execPkg::*;

    logic [DATA_WIDTH-1:0] a, b, sum, shiftOut;

    assign a = ctrl.invA ? ~opA : opA;
    assign b = ctrl.invB ? ~opB : opB;

    assign {carryOut, sum} = {1'b0, a} + {1'b0, b} + {{DATA_WIDTH{1'b0}}, ctrl.cin};

    // operands agree in sign but the sum does not
    assign overflow = ctrl.sign & (a[DATA_WIDTH-1] == b[DATA_WIDTH-1])
                    & (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);

    shifter i_shifter (
        .data    (opA),
        .amount  (opB[3:0]),
        .mode    (ctrl.op[1:0]),   // shift ops occupy codes 0 to 3
        .shifted (shiftOut)
    );

    always_comb begin
        case (ctrl.op)
            ALU_ADD: aluOut = sum;
            ALU_OR:  aluOut = a | b;
            ALU_XOR: aluOut = a ^ b;
            ALU_AND: aluOut = a & b;
            default: aluOut = shiftOut;
        endcase
    end

    assign zero     = (aluOut == '0);
    assign negative = aluOut[DATA_WIDTH-1];

    // control must not leave a carry-in on shift decodes
    shiftNoCin: assert final (ctrl.op inside {ALU_ADD, ALU_OR, ALU_XOR, ALU_AND} || !ctrl.cin)
        else $error("aluCore: carry-in set on shift op %s", ctrl.op.name());

endmodule

// ==== resultStage.sv ====
module resultStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid,
    input  logic [isaPkg::DATA_WIDTH-1:0]   rs,
    input  execPkg::resultSel_t             resultSel,
    input  logic [isaPkg::DATA_WIDTH-1:0]   aluOut,
    input  logic                            carryOut,
    input  logic                            overflow,
    input  logic                            zero,
    input  logic                            negative,
    output execPkg::execResult_t            result
);
    import isaPkg::*;
    import execPkg::*;

    logic [DATA_WIDTH-1:0] reversed, nextValue, valueQ;
    logic lessThan, nextWriteEn, nextIsBranch, nextTaken;
    logic validQ, writeEnQ, isBranchQ, takenQ;

    assign lessThan = negative ^ overflow;   // signed rs < rt

    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            reversed[i] = rs[DATA_WIDTH-1-i];
        end
    end

    always_comb begin
        nextValue    = aluOut;
        nextWriteEn  = 1'b1;
        nextIsBranch = 1'b0;
        nextTaken    = 1'b0;
        case (resultSel)
            RES_ALU:   ;
            RES_SEQ:   nextValue = {{(DATA_WIDTH-1){1'b0}}, zero};
            RES_SLT:   nextValue = {{(DATA_WIDTH-1){1'b0}}, lessThan};
            RES_SLE:   nextValue = {{(DATA_WIDTH-1){1'b0}}, lessThan | zero};
            RES_SCO:   nextValue = {{(DATA_WIDTH-1){1'b0}}, carryOut};
            RES_BTR:   nextValue = reversed;
            RES_STORE: nextWriteEn = 1'b0;   // value carries the address
            RES_BLTZ, RES_BGEZ: begin
                nextValue    = '0;
                nextWriteEn  = 1'b0;
                nextIsBranch = 1'b1;
                nextTaken    = (resultSel == RES_BLTZ) ? negative : ~negative;
            end
            default: begin   // nop, halt, unknown
                nextValue   = '0;
                nextWriteEn = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validQ    <= 1'b0;
            writeEnQ  <= 1'b0;
            isBranchQ <= 1'b0;
            takenQ    <= 1'b0;
        end else begin
            validQ    <= valid;
            writeEnQ  <= valid & nextWriteEn;
            isBranchQ <= valid & nextIsBranch;
            takenQ    <= valid & nextTaken;
        end
    end

    always_ff @(posedge clk) begin
        valueQ <= nextValue;
    end

    assign result = '{valid: validQ, writeEn: writeEnQ, value: valueQ,
                      isBranch: isBranchQ, branchTaken: takenQ};

    branchNoWrite: assert property (@(posedge clk) disable iff (reset)
        !(result.isBranch && result.writeEn))
        else $error("resultStage: branch result also requests a register write");

endmodule

// ==== executeUnit.sv ====
module executeUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  execPkg::execReq_t     req,
    output execPkg::execResult_t  result
);
    import isaPkg::*;
    import execPkg::*;

    aluCtrl_t              ctrl;
    logic [DATA_WIDTH-1:0] opA, opB, aluOut;
    logic                  carryOut, overflow, zero, negative;

    aluControl i_aluControl (
        .opcode (req.opcode),
        .funct  (req.funct),
        .ctrl   (ctrl)
    );

    operandSelect i_operandSelect (
        .opcode (req.opcode),
        .rs     (req.rs),
        .rt     (req.rt),
        .imm    (req.imm),
        .opA    (opA),
        .opB    (opB)
    );

    aluCore i_aluCore (
        .opA      (opA),
        .opB      (opB),
        .ctrl     (ctrl),
        .aluOut   (aluOut),
        .carryOut (carryOut),
        .overflow (overflow),
        .zero     (zero),
        .negative (negative)
    );

    resultStage i_resultStage (
        .clk       (clk),
        .reset     (reset),
        .valid     (req.valid),
        .rs        (req.rs),   // btr works on the raw register
        .resultSel (ctrl.resultSel),
        .aluOut    (aluOut),
        .carryOut  (carryOut),
        .overflow  (overflow),
        .zero      (zero),
        .negative  (negative),
        .result    (result)
    );

endmodule

// ==== executeUnitTb.sv ====
module executeUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;
    import execPkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int RANDOM_COUNT   = 2000;
    localparam int EDGE_COUNT     = 6;
    localparam int DIRECTED_COUNT = 32 * 4 + 2 * 4 * 16 + 6 * EDGE_COUNT * EDGE_COUNT;
    // random gaps add about one idle cycle in four, then doubled for margin
    localparam int CYCLE_LIMIT    = 2 * (RESET_CYCLES + DIRECTED_COUNT + RANDOM_COUNT * 5 / 4);

    localparam logic [DATA_WIDTH-1:0] EDGE_VALUES [EDGE_COUNT] = '{
        16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hfffe, 16'hffff
    };
    localparam opcode_t COMPARE_OPS [6] = '{OP_SEQ, OP_SLT, OP_SLE, OP_SCO, OP_BLTZ, OP_BGEZ};
    localparam opcode_t SHIFT_IMM_OPS [4] = '{OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};

    logic        clk = 1'b0;
    logic        reset;
    execReq_t    req;
    execResult_t result;
    execResult_t expected;
    execResult_t prevExpected;
    logic        prevValid;
    opcode_t     prevOpcode;
    integer      seed = 32'hbd4b_4bf1;
    int          errorCount = 0;
    int          cycleCount = 0;

    executeUnit i_executeUnit (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .result (result)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [DATA_WIDTH-1:0] shiftRef(input logic [DATA_WIDTH-1:0] x,
                                                      input logic [3:0] n, input funct_t mode);
        logic [2*DATA_WIDTH-1:0] doubled;
        doubled = {x, x};
        case (mode)
            FN_ROL:  return DATA_WIDTH'(doubled >> (DATA_WIDTH - n));
            FN_SLL:  return x << n;
            FN_ROR:  return DATA_WIDTH'(doubled >> n);
            default: return x >> n;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] reverseBits(input logic [DATA_WIDTH-1:0] x);
        logic [DATA_WIDTH-1:0] r;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            r[DATA_WIDTH-1-i] = x[i];
        end
        return r;
    endfunction

    // reference result for one request
    function automatic execResult_t expectedFor(input execReq_t r);
        execResult_t e;
        logic [DATA_WIDTH-1:0] s5, z5, s8, z8;
        logic [DATA_WIDTH:0] wide;
        s5 = {{(DATA_WIDTH-5){r.imm[4]}}, r.imm[4:0]};
        z5 = {{(DATA_WIDTH-5){1'b0}}, r.imm[4:0]};
        s8 = {{(DATA_WIDTH-8){r.imm[7]}}, r.imm};
        z8 = {{(DATA_WIDTH-8){1'b0}}, r.imm};
        wide = {1'b0, r.rs} + {1'b0, r.rt};
        e = '0;
        e.valid   = 1'b1;
        e.writeEn = 1'b1;
        case (r.opcode)
            OP_ADDI:           e.value = r.rs + s5;
            OP_SUBI:           e.value = s5 - r.rs;
            OP_XORI:           e.value = r.rs ^ z5;
            OP_ANDNI:          e.value = r.rs & ~z5;
            OP_ROLI:           e.value = shiftRef(r.rs, r.imm[3:0], FN_ROL);
            OP_SLLI:           e.value = shiftRef(r.rs, r.imm[3:0], FN_SLL);
            OP_RORI:           e.value = shiftRef(r.rs, r.imm[3:0], FN_ROR);
            OP_SRLI:           e.value = shiftRef(r.rs, r.imm[3:0], FN_SRL);
            OP_LD, OP_STU:     e.value = r.rs + s5;
            OP_LBI:            e.value = s8;
            OP_SLBI:           e.value = (r.rs << 8) | z8;
            OP_BTR:            e.value = reverseBits(r.rs);
            OP_SHIFT:          e.value = shiftRef(r.rs, r.rt[3:0], r.funct);
            OP_SEQ:            e.value = (r.rs == r.rt) ? 16'd1 : 16'd0;
            OP_SLT:            e.value = ($signed(r.rs) < $signed(r.rt)) ? 16'd1 : 16'd0;
            OP_SLE:            e.value = ($signed(r.rs) <= $signed(r.rt)) ? 16'd1 : 16'd0;
            OP_SCO:            e.value = {{(DATA_WIDTH-1){1'b0}}, wide[DATA_WIDTH]};
            OP_ST: begin
                e.value   = r.rs + s5;   // address only
                e.writeEn = 1'b0;
            end
            OP_ARITH: begin
                case (r.funct)
                    FN_ADD:  e.value = r.rs + r.rt;
                    FN_SUB:  e.value = r.rt - r.rs;
                    FN_XOR:  e.value = r.rs ^ r.rt;
                    default: e.value = r.rs & ~r.rt;
                endcase
            end
            OP_BLTZ, OP_BGEZ: begin
                e.writeEn     = 1'b0;
                e.isBranch    = 1'b1;
                e.branchTaken = (r.opcode == OP_BLTZ) ? r.rs[DATA_WIDTH-1] : !r.rs[DATA_WIDTH-1];
            end
            default: e.writeEn = 1'b0;   // nop, halt, unused encodings
        endcase
        return e;
    endfunction

    function automatic execReq_t makeReq(input opcode_t op, input funct_t fn,
                                         input logic [DATA_WIDTH-1:0] rs,
                                         input logic [DATA_WIDTH-1:0] rt,
                                         input logic [IMM_WIDTH-1:0] imm);
        execReq_t r;
        r.valid  = 1'b1;
        r.opcode = op;
        r.funct  = fn;
        r.rs     = rs;
        r.rt     = rt;
        r.imm    = imm;
        return r;
    endfunction

    task automatic issue(input execReq_t r);
        @(negedge clk);
        req      = r;
        expected = expectedFor(r);
    endtask

    task automatic idle();
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            prevValid <= 1'b0;
        end else begin
            prevValid <= req.valid;
        end
        prevExpected <= expected;
        prevOpcode   <= req.opcode;
    end

    validMatch: assert property (@(posedge clk) disable iff (reset)
        result.valid == prevValid)
        else begin
            errorCount++;
            $display("[ERROR] %0t: result.valid is %b, expected %b", $time,
                     $sampled(result.valid), $sampled(prevValid));
        end

    flagsMatch: assert property (@(posedge clk) disable iff (reset)
        prevValid |-> result.writeEn == prevExpected.writeEn
                      && result.isBranch == prevExpected.isBranch
                      && result.branchTaken == prevExpected.branchTaken)
        else begin
            errorCount++;
            $display("[ERROR] %0t: opcode %b flags wr/br/tk %b%b%b, expected %b%b%b", $time,
                     $sampled(prevOpcode), $sampled(result.writeEn),
                     $sampled(result.isBranch), $sampled(result.branchTaken),
                     $sampled(prevExpected.writeEn), $sampled(prevExpected.isBranch),
                     $sampled(prevExpected.branchTaken));
        end

    valueMatch: assert property (@(posedge clk) disable iff (reset)
        prevValid |-> result.value == prevExpected.value)
        else begin
            errorCount++;
            $display("[ERROR] %0t: opcode %b value %h, expected %h", $time,
                     $sampled(prevOpcode), $sampled(result.value),
                     $sampled(prevExpected.value));
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        execReq_t r;
        reset    = 1'b1;
        req      = '0;
        expected = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);   // idle window before the first request

        // every encoding with every funct, unused opcodes included
        for (int op = 0; op < 32; op++) begin
            for (int fn = 0; fn < 4; fn++) begin
                issue(makeReq(opcode_t'(5'(op)), 2'(fn), 16'($random(seed)),
                              16'($random(seed)), 8'($random(seed))));
            end
        end

        // all shift amounts, register and immediate forms
        for (int amt = 0; amt < 16; amt++) begin
            for (int fn = 0; fn < 4; fn++) begin
                r = makeReq(OP_SHIFT, 2'(fn), 16'($random(seed)), 16'($random(seed)),
                            8'($random(seed)));
                r.rt[3:0] = 4'(amt);
                issue(r);
                r = makeReq(SHIFT_IMM_OPS[fn], 2'($random(seed)), 16'($random(seed)),
                            16'($random(seed)), 8'($random(seed)));
                r.imm[3:0] = 4'(amt);
                issue(r);
            end
        end

        // compares and branches around the signed overflow corner
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < EDGE_COUNT; i++) begin
                for (int j = 0; j < EDGE_COUNT; j++) begin
                    issue(makeReq(COMPARE_OPS[k], 2'b00, EDGE_VALUES[i], EDGE_VALUES[j], 8'h00));
                end
            end
        end

        for (int n = 0; n < RANDOM_COUNT; n++) begin
            issue(makeReq(opcode_t'(5'($random(seed))), 2'($random(seed)),
                          16'($random(seed)), 16'($random(seed)), 8'($random(seed))));
            if (($random(seed) & 3) == 0) begin
                idle();
            end
        end
        idle();
        repeat (2) @(negedge clk);   // let the last result be checked

        $display("checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
isaPkg.sv
execPkg.sv
aluControl.sv
operandSelect.sv
shifter.sv
aluCore.sv
resultStage.sv
executeUnit.sv
executeUnitTb.sv

// ==== Bender.yml ====
package:
  name: execute_unit

sources:
  - isaPkg.sv
  - execPkg.sv
  - aluControl.sv
  - operandSelect.sv
  - shifter.sv
  - aluCore.sv
  - resultStage.sv
  - executeUnit.sv
  - target: test
    files:
      - executeUnitTb.sv
